// ==== tile_top.f ====
tile_pkg.sv
tile_rename.sv
tile_resource_alloc.sv
tile_alu_rs.sv
tile_alu.sv
tile_phy_regfile.sv
tile_rob.sv
tile_top.sv
tile_tb_clk.sv
tile_tb.sv

// ==== Makefile ====
VERILATOR  := verilator
FILELIST   := tile_top.f
TOP        := tile_tb
RTL_TOP    := tile_top
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)

// ==== tile_tb.sv ====
`timescale 1ns/1ps

module tile_tb
  import tile_pkg::*;
();

  // About 150 instructions at 20 cycles each plus margin
  localparam int TIMEOUT_CYC = 4000;
  localparam int EXP_DEPTH   = 256;

  logic       clk;
  logic       rst_n;
  logic       disp_valid;
  disp_inst_t disp;
  logic       disp_ready;
  commit_t    commit;

  // Reference model state and expected commit queue
  data_t arch[AREG_NUM];
  areg_t exp_areg[EXP_DEPTH];
  data_t exp_data[EXP_DEPTH];
  int    exp_wr = 0;
  int    exp_rd = 0;

  // Architectural registers not yet overwritten since reset
  logic [AREG_NUM-1:0] fresh_map = '1;

  int   disp_cnt   = 0;
  int   commit_cnt = 0;
  int   busy_cnt   = 0;
  int   cyc_cnt    = 0;
  int   test_cnt   = 0;
  logic cmt_pend   = 1'b0;
  logic post_rst   = 1'b0;

  int reset_errs = 0;
  int order_errs = 0;
  int value_errs = 0;
  int check_errs = 0;

  tile_tb_clk u_clk (
    .o_clk   (clk),
    .o_rst_n (rst_n)
  );

  tile_top DUT (
    .i_clk        (clk),
    .i_rst_n      (rst_n),
    .i_disp_valid (disp_valid),
    .i_disp       (disp),
    .o_disp_ready (disp_ready),
    .o_commit     (commit)
  );

  // ------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------
  function automatic data_t expected_result(alu_op_e op, data_t a, data_t b, data_t imm);
    case (op)
      LI:      return imm;
      ADD:     return a + b;
      SUB:     return a - b;
      AND:     return a & b;
      XOR:     return a ^ b;
      default: return '0;
    endcase
  endfunction

  // Evaluated in program order at acceptance
  function automatic void model_accept(disp_inst_t inst);
    data_t res;
    res = expected_result(inst.op, arch[inst.rs1], arch[inst.rs2], inst.imm);
    arch[inst.rd]    = res;
    exp_areg[exp_wr] = inst.rd;
    exp_data[exp_wr] = res;
    exp_wr++;
  endfunction

  function automatic disp_inst_t make_inst(alu_op_e op, int rd, int rs1, int rs2, data_t imm);
    disp_inst_t inst;
    inst.op  = op;
    inst.rd  = areg_t'(rd);
    inst.rs1 = areg_t'(rs1);
    inst.rs2 = areg_t'(rs2);
    inst.imm = imm;
    return inst;
  endfunction

  function automatic alu_op_e rand_op(logic with_li);
    int lo;
    lo = with_li ? 0 : 1;
    return alu_op_e'($urandom_range(4, lo));
  endfunction

  function automatic int error_total();
    return reset_errs + order_errs + value_errs + check_errs;
  endfunction

  // ------------------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------------------
  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic idle(int n);
    repeat (n) step();
  endtask

  // Holds the instruction until an edge with ready high
  task automatic send(disp_inst_t inst);
    logic took;
    disp_valid = 1'b1;
    disp       = inst;
    do begin
      @(negedge clk);
      took = disp_ready;
      step();
    end while (!took);
    disp_valid = 1'b0;
    disp_cnt++;
    model_accept(inst);
  endtask

  task automatic drain();
    while (commit_cnt < disp_cnt) begin
      step();
    end
    idle(4);
  endtask

  task automatic finish_test(string name, int errs_at_start, int n_inst);
    test_cnt++;
    $display("Test %-12s finished: %0d instructions, %0d errors",
             name, n_inst, error_total() - errs_at_start);
  endtask

  // ------------------------------------------------------------
  // Monitors and timeout
  // ------------------------------------------------------------
  always @(negedge clk) begin
    cmt_pend <= rst_n & commit.valid;
    if (rst_n && commit.valid) begin
      commit_cnt                <= commit_cnt + 1;
      fresh_map[commit.rd_areg] <= 1'b0;
    end
    if (rst_n && !disp_ready) begin
      busy_cnt <= busy_cnt + 1;
    end
  end

  // Queue head moves on after the falling-edge check
  always @(posedge clk) begin
    if (cmt_pend) begin
      exp_rd <= exp_rd + 1;
    end
  end

  always @(posedge clk) begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_cnt == TIMEOUT_CYC) begin
      $display("Run timed out after %0d cycles, %0d of %0d instructions committed",
               TIMEOUT_CYC, commit_cnt, disp_cnt);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // Checks at the falling edge
  // ------------------------------------------------------------
  reset_state_chk: assert property (@(negedge clk)
    (!rst_n || post_rst) |-> (!commit.valid && disp_ready))
    else begin
      reset_errs++;
      $display("MISMATCH at %0t: reset state commit valid %b ready %b, expected 0 and 1",
               $time, commit.valid, disp_ready);
    end

  commit_known_chk: assert property (@(negedge clk) disable iff (!rst_n)
    commit.valid |-> (exp_rd < exp_wr))
    else begin
      order_errs++;
      $display("At %0t a commit came out with no dispatched instruction left", $time);
    end

  commit_value_chk: assert property (@(negedge clk) disable iff (!rst_n)
    (commit.valid && exp_rd < exp_wr) |->
      (commit.rd_areg == exp_areg[exp_rd] && commit.data == exp_data[exp_rd]))
    else begin
      value_errs++;
      $display("MISMATCH at %0t: commit %0d gave r%0d = %h, expected r%0d = %h",
               $time, exp_rd, commit.rd_areg, commit.data,
               exp_areg[exp_rd], exp_data[exp_rd]);
    end

  // First overwrite of a register after reset frees its identity mapping
  reset_map_chk: assert property (@(negedge clk) disable iff (!rst_n)
    (commit.valid && fresh_map[commit.rd_areg]) |->
      (commit.free_preg == preg_t'(commit.rd_areg)))
    else begin
      value_errs++;
      $display("MISMATCH at %0t: first commit to r%0d freed p%0d, expected p%0d",
               $time, commit.rd_areg, commit.free_preg, commit.rd_areg);
    end

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin
    int errs0;
    int first;
    int start_cmt;
    int start_busy;
    int prev_rd;
    int rd;
    disp_valid = 1'b0;
    disp       = '0;
    for (int i = 0; i < AREG_NUM; i++) begin
      arch[i] = '0;
    end
    void'($urandom(37));

    // Reset state followed by a few idle cycles
    errs0 = error_total();
    wait (rst_n === 1'b1);
    post_rst = 1'b1;
    idle(3);
    post_rst = 1'b0;
    finish_test("reset_state", errs0, 0);

    // One LI per register followed by each ALU op
    errs0 = error_total();
    first = disp_cnt;
    for (int r = 0; r < AREG_NUM; r++) begin
      send(make_inst(LI, r, 0, 0, $urandom()));
    end
    send(make_inst(ADD, 1, 2, 3, '0));
    send(make_inst(SUB, 4, 5, 6, '0));
    send(make_inst(AND, 7, 0, 1, '0));
    send(make_inst(XOR, 0, 4, 7, '0));
    drain();
    finish_test("op_results", errs0, disp_cnt - first);

    // Each op reads the destination of the one before
    errs0 = error_total();
    first = disp_cnt;
    prev_rd = $urandom_range(AREG_NUM - 1);
    send(make_inst(LI, prev_rd, 0, 0, $urandom()));
    for (int k = 0; k < 15; k++) begin
      rd = $urandom_range(AREG_NUM - 1);
      send(make_inst(rand_op(1'b0), rd, prev_rd, $urandom_range(AREG_NUM - 1), '0));
      prev_rd = rd;
    end
    drain();
    finish_test("dep_chain", errs0, disp_cnt - first);

    // Chain on r1 holds the station and ROB head while loads pile up
    errs0      = error_total();
    first      = disp_cnt;
    start_cmt  = commit_cnt;
    start_busy = busy_cnt;
    send(make_inst(LI, 1, 0, 0, $urandom()));
    for (int k = 0; k < 5; k++) begin
      send(make_inst(ADD, 1, 1, 2, '0));
    end
    for (int k = 0; k < 14; k++) begin
      send(make_inst(LI, 2 + k % 6, 0, 0, $urandom()));
    end
    drain();
    assert (busy_cnt > start_busy)
      else begin
        check_errs++;
        $display("Dispatch ready never went low during the burst");
      end
    assert (commit_cnt - start_cmt == 20)
      else begin
        check_errs++;
        $display("Burst committed %0d instructions but 20 were dispatched",
                 commit_cnt - start_cmt);
      end
    finish_test("back_press", errs0, disp_cnt - first);

    // Random mix with idle gaps that recycles the free list many times
    errs0 = error_total();
    first = disp_cnt;
    for (int k = 0; k < 100; k++) begin
      if ($urandom_range(3) == 0) begin
        idle(1);
      end
      send(make_inst(rand_op(1'b1), $urandom_range(AREG_NUM - 1),
                     $urandom_range(AREG_NUM - 1), $urandom_range(AREG_NUM - 1),
                     $urandom()));
    end
    drain();
    finish_test("recycle", errs0, disp_cnt - first);

    $display("Summary: %0d tests, %0d dispatched, %0d committed, %0d errors",
             test_cnt, disp_cnt, commit_cnt, error_total());
    if (error_total() == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== tile_tb_clk.sv ====
`timescale 1ns/1ps

module tile_tb_clk (
  output logic o_clk,
  output logic o_rst_n
);

  // 40 ns period
  initial begin
    o_clk = 1'b0;
    forever #20 o_clk = ~o_clk;
  end

  // Reset held low for eight rising edges
  initial begin
    o_rst_n = 1'b0;
    repeat (8) @(posedge o_clk);
    #2 o_rst_n = 1'b1;
  end

endmodule

// ==== tile_top.sv ====
`timescale 1ns/1ps

module tile_top
  import tile_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_rst_n,
  input  logic       i_disp_valid,
  input  disp_inst_t i_disp,
  output logic       o_disp_ready,
  output commit_t    o_commit
);

  // ------------------------------------------------------------
  // Internal broadcasts
  // ------------------------------------------------------------
  rn_inst_t  w_rn_inst;
  issue_t    w_issue;
  phy_wr_t   w_phy_wr;
  done_rpt_t w_done_rpt;
  rob_id_t   w_rob_id;
  logic      w_rs_credit_ret;

  // Register read port
  preg_t w_rs1_addr;
  preg_t w_rs2_addr;
  data_t w_rs1_data;
  data_t w_rs2_data;

  tile_rename u_rename (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_disp_valid (i_disp_valid),
    .i_disp       (i_disp),
    .i_disp_ready (o_disp_ready),
    .i_rob_id     (w_rob_id),
    .i_phy_wr     (w_phy_wr),
    .i_commit     (o_commit),
    .o_rn_inst    (w_rn_inst)
  );

  tile_resource_alloc u_resource_alloc (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_disp_valid    (i_disp_valid),
    .i_rs_credit_ret (w_rs_credit_ret),
    .i_commit        (o_commit),
    .o_disp_ready    (o_disp_ready)
  );

  tile_alu_rs u_alu_rs (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_rn_inst    (w_rn_inst),
    .i_phy_wr     (w_phy_wr),
    .o_issue      (w_issue),
    .o_credit_ret (w_rs_credit_ret)
  );

  tile_alu u_alu (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_issue    (w_issue),
    .i_rs1_data (w_rs1_data),
    .i_rs2_data (w_rs2_data),
    .o_rs1_addr (w_rs1_addr),
    .o_rs2_addr (w_rs2_addr),
    .o_phy_wr   (w_phy_wr),
    .o_done_rpt (w_done_rpt)
  );

  tile_phy_regfile u_phy_regfile (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_rd_addr0 (w_rs1_addr),
    .i_rd_addr1 (w_rs2_addr),
    .o_rd_data0 (w_rs1_data),
    .o_rd_data1 (w_rs2_data),
    .i_phy_wr   (w_phy_wr)
  );

  tile_rob u_rob (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_rn_inst  (w_rn_inst),
    .i_done_rpt (w_done_rpt),
    .o_rob_id   (w_rob_id),
    .o_commit   (o_commit)
  );

endmodule

// ==== tile_rob.sv ====
`timescale 1ns/1ps

module tile_rob
  import tile_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst_n,
  input  rn_inst_t  i_rn_inst,
  input  done_rpt_t i_done_rpt,
  output rob_id_t   o_rob_id,
  output commit_t   o_commit
);

  logic [ROB_SIZE-1:0] ent_used;
  logic [ROB_SIZE-1:0] ent_done;
  areg_t               ent_areg[ROB_SIZE];
  preg_t               ent_old [ROB_SIZE];
  data_t               ent_data[ROB_SIZE];
  rob_id_t             head;
  rob_id_t             tail;
  logic                w_cmt;

  // Next id skips the slot that rename is about to fill
  assign o_rob_id = tail + rob_id_t'(i_rn_inst.valid);

  assign w_cmt = ent_used[head] & ent_done[head];

  // ------------------------------------------------------------
  // Pointers and status
  // ------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ent_used <= '0;
      ent_done <= '0;
      head     <= '0;
      tail     <= '0;
    end else begin
      if (i_rn_inst.valid) begin
        ent_used[tail] <= 1'b1;
        ent_done[tail] <= 1'b0;
        tail           <= tail + 1'b1;
      end
      if (i_done_rpt.valid) begin
        ent_done[i_done_rpt.rob_id] <= 1'b1;
      end
      if (w_cmt) begin
        ent_used[head] <= 1'b0;
        head           <= head + 1'b1;
      end
    end
  end

  // Entry payload
  always_ff @(posedge i_clk) begin
    if (i_rn_inst.valid) begin
      ent_areg[tail] <= i_rn_inst.rd_areg;
      ent_old[tail]  <= i_rn_inst.old_preg;
    end
    if (i_done_rpt.valid) begin
      ent_data[i_done_rpt.rob_id] <= i_done_rpt.data;
    end
  end

  // ------------------------------------------------------------
  // In-order commit of one entry per cycle
  // ------------------------------------------------------------
  always_comb begin
    o_commit.valid     = w_cmt;
    o_commit.rd_areg   = ent_areg[head];
    o_commit.free_preg = ent_old[head];
    o_commit.data      = ent_data[head];
  end

endmodule

// ==== tile_phy_regfile.sv ====
`timescale 1ns/1ps

module tile_phy_regfile
  import tile_pkg::*;
(
  input  logic    i_clk,
  input  logic    i_rst_n,
  input  preg_t   i_rd_addr0,
  input  preg_t   i_rd_addr1,
  output data_t   o_rd_data0,
  output data_t   o_rd_data1,
  input  phy_wr_t i_phy_wr
);

  data_t regs[PREG_NUM];

  // Same-cycle write is seen by the reader
  function automatic data_t rd_bypass(preg_t addr);
    data_t val;
    val = regs[addr];
    if (i_phy_wr.valid && (i_phy_wr.preg == addr)) begin
      val = i_phy_wr.data;
    end
    return val;
  endfunction

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < PREG_NUM; i++) begin
        regs[i] <= '0;
      end
    end else if (i_phy_wr.valid) begin
      regs[i_phy_wr.preg] <= i_phy_wr.data;
    end
  end

  always_comb o_rd_data0 = rd_bypass(i_rd_addr0);
  always_comb o_rd_data1 = rd_bypass(i_rd_addr1);

endmodule

// ==== tile_alu.sv ====
`timescale 1ns/1ps

module tile_alu
  import tile_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst_n,
  input  issue_t    i_issue,
  input  data_t     i_rs1_data,
  input  data_t     i_rs2_data,
  output preg_t     o_rs1_addr,
  output preg_t     o_rs2_addr,
  output phy_wr_t   o_phy_wr,
  output done_rpt_t o_done_rpt
);

  logic    ex1_valid;
  alu_op_e ex1_op;
  rob_id_t ex1_rob_id;
  preg_t   ex1_rd_preg;
  data_t   ex1_imm;
  data_t   ex1_rs1;
  data_t   ex1_rs2;
  data_t   w_result;

  // Register file read happens in the issue cycle
  assign o_rs1_addr = i_issue.rs1_preg;
  assign o_rs2_addr = i_issue.rs2_preg;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ex1_valid <= 1'b0;
    end else begin
      ex1_valid <= i_issue.valid;
      if (i_issue.valid) begin
        ex1_op      <= i_issue.op;
        ex1_rob_id  <= i_issue.rob_id;
        ex1_rd_preg <= i_issue.rd_preg;
        ex1_imm     <= i_issue.imm;
        ex1_rs1     <= i_rs1_data;
        ex1_rs2     <= i_rs2_data;
      end
    end
  end

  always_comb begin
    case (ex1_op)
      LI:      w_result = ex1_imm;
      ADD:     w_result = ex1_rs1 + ex1_rs2;
      SUB:     w_result = ex1_rs1 - ex1_rs2;
      AND:     w_result = ex1_rs1 & ex1_rs2;
      XOR:     w_result = ex1_rs1 ^ ex1_rs2;
      default: w_result = '0;
    endcase
  end

  // Writeback and done report leave together
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_phy_wr.valid   <= 1'b0;
      o_done_rpt.valid <= 1'b0;
    end else begin
      o_phy_wr.valid   <= ex1_valid;
      o_done_rpt.valid <= ex1_valid;
      if (ex1_valid) begin
        o_phy_wr.preg     <= ex1_rd_preg;
        o_phy_wr.data     <= w_result;
        o_done_rpt.rob_id <= ex1_rob_id;
        o_done_rpt.data   <= w_result;
      end
    end
  end

endmodule

// ==== tile_alu_rs.sv ====
`timescale 1ns/1ps

module tile_alu_rs
  import tile_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_rst_n,
  input  rn_inst_t i_rn_inst,
  input  phy_wr_t  i_phy_wr,
  output issue_t   o_issue,
  output logic     o_credit_ret
);

  typedef logic [$clog2(RS_SIZE)-1:0] rs_idx_t;

  rn_inst_t           ent[RS_SIZE];
  logic [RS_SIZE-1:0] w_rs1_wake;
  logic [RS_SIZE-1:0] w_rs2_wake;
  logic [RS_SIZE-1:0] w_rdy;
  logic [RS_SIZE-1:0] w_free;
  rs_idx_t            w_iss_idx;
  rs_idx_t            w_wr_idx;
  logic               w_iss_fire;
  logic               w_new_rs1_rdy;
  logic               w_new_rs2_rdy;

  // ------------------------------------------------------------
  // Wakeup on writeback tag match
  // ------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < RS_SIZE; i++) begin
      w_rs1_wake[i] = i_phy_wr.valid & (i_phy_wr.preg == ent[i].rs1_preg);
      w_rs2_wake[i] = i_phy_wr.valid & (i_phy_wr.preg == ent[i].rs2_preg);
      w_rdy[i]      = ent[i].valid & (ent[i].rs1_ready | w_rs1_wake[i]) &
                      (ent[i].rs2_ready | w_rs2_wake[i]);
      w_free[i]     = ~ent[i].valid;
    end
  end

  assign w_new_rs1_rdy = i_rn_inst.rs1_ready |
                         (i_phy_wr.valid & (i_phy_wr.preg == i_rn_inst.rs1_preg));
  assign w_new_rs2_rdy = i_rn_inst.rs2_ready |
                         (i_phy_wr.valid & (i_phy_wr.preg == i_rn_inst.rs2_preg));

  // Lowest index wins for both issue and the write slot
  always_comb begin
    w_iss_fire = 1'b0;
    w_iss_idx  = '0;
    w_wr_idx   = '0;
    for (int i = RS_SIZE - 1; i >= 0; i--) begin
      if (w_rdy[i]) begin
        w_iss_fire = 1'b1;
        w_iss_idx  = rs_idx_t'(i);
      end
      if (w_free[i]) begin
        w_wr_idx = rs_idx_t'(i);
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < RS_SIZE; i++) begin
        ent[i].valid <= 1'b0;
      end
      o_credit_ret <= 1'b0;
    end else begin
      o_credit_ret <= w_iss_fire;
      for (int i = 0; i < RS_SIZE; i++) begin
        if (w_rs1_wake[i]) begin
          ent[i].rs1_ready <= 1'b1;
        end
        if (w_rs2_wake[i]) begin
          ent[i].rs2_ready <= 1'b1;
        end
      end
      if (w_iss_fire) begin
        ent[w_iss_idx].valid <= 1'b0;
      end
      // Allocator credits guarantee a free slot here
      if (i_rn_inst.valid) begin
        ent[w_wr_idx]           <= i_rn_inst;
        ent[w_wr_idx].rs1_ready <= w_new_rs1_rdy;
        ent[w_wr_idx].rs2_ready <= w_new_rs2_rdy;
      end
    end
  end

  always_comb begin
    o_issue.valid    = w_iss_fire;
    o_issue.op       = ent[w_iss_idx].op;
    o_issue.rob_id   = ent[w_iss_idx].rob_id;
    o_issue.rd_preg  = ent[w_iss_idx].rd_preg;
    o_issue.rs1_preg = ent[w_iss_idx].rs1_preg;
    o_issue.rs2_preg = ent[w_iss_idx].rs2_preg;
    o_issue.imm      = ent[w_iss_idx].imm;
  end

endmodule

// ==== tile_resource_alloc.sv ====
`timescale 1ns/1ps

module tile_resource_alloc
  import tile_pkg::*;
(
  input  logic    i_clk,
  input  logic    i_rst_n,
  input  logic    i_disp_valid,
  input  logic    i_rs_credit_ret,
  input  commit_t i_commit,
  output logic    o_disp_ready
);

  // Wide enough for the largest credit pool
  typedef logic [$clog2(ROB_SIZE + 1)-1:0] cnt_t;

  cnt_t rob_cnt;
  cnt_t rs_cnt;
  cnt_t reg_cnt;
  logic w_accept;

  function automatic cnt_t upd_credit(cnt_t cnt, logic take, logic give);
    cnt_t nxt;
    nxt = cnt;
    if (take) begin
      nxt = nxt - 1'b1;
    end
    if (give) begin
      nxt = nxt + 1'b1;
    end
    return nxt;
  endfunction

  assign w_accept = i_disp_valid & o_disp_ready;

  // Every pool must hold a credit before the next dispatch
  assign o_disp_ready = (rob_cnt != '0) & (rs_cnt != '0) & (reg_cnt != '0);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rob_cnt <= cnt_t'(ROB_SIZE);
      rs_cnt  <= cnt_t'(RS_SIZE);
      reg_cnt <= cnt_t'(FREE_REG_NUM);
    end else begin
      rob_cnt <= upd_credit(rob_cnt, w_accept, i_commit.valid);
      rs_cnt  <= upd_credit(rs_cnt, w_accept, i_rs_credit_ret);
      // Old register goes back to the free list on commit
      reg_cnt <= upd_credit(reg_cnt, w_accept, i_commit.valid);
    end
  end

endmodule

// ==== tile_rename.sv ====
`timescale 1ns/1ps

module tile_rename
  import tile_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_rst_n,
  input  logic       i_disp_valid,
  input  disp_inst_t i_disp,
  input  logic       i_disp_ready,
  input  rob_id_t    i_rob_id,
  input  phy_wr_t    i_phy_wr,
  input  commit_t    i_commit,
  output rn_inst_t   o_rn_inst
);

  preg_t                           map_tbl  [AREG_NUM];
  preg_t                           free_list[FREE_REG_NUM];
  logic [PREG_NUM-1:0]             ready_tbl;
  logic [$clog2(FREE_REG_NUM)-1:0] fl_head;
  logic [$clog2(FREE_REG_NUM)-1:0] fl_tail;

  logic  w_accept;
  preg_t w_new_preg;
  preg_t w_rs1_preg;
  preg_t w_rs2_preg;
  logic  w_rs1_ready;
  logic  w_rs2_ready;

  assign w_accept   = i_disp_valid & i_disp_ready;
  assign w_new_preg = free_list[fl_head];
  assign w_rs1_preg = map_tbl[i_disp.rs1];
  assign w_rs2_preg = map_tbl[i_disp.rs2];

  // LI has no real sources; a writeback this cycle counts as ready
  assign w_rs1_ready = (i_disp.op == LI) | ready_tbl[w_rs1_preg] |
                       (i_phy_wr.valid & (i_phy_wr.preg == w_rs1_preg));
  assign w_rs2_ready = (i_disp.op == LI) | ready_tbl[w_rs2_preg] |
                       (i_phy_wr.valid & (i_phy_wr.preg == w_rs2_preg));

  // Map table starts as identity
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < AREG_NUM; i++) begin
        map_tbl[i] <= preg_t'(i);
      end
    end else if (w_accept) begin
      map_tbl[i_disp.rd] <= w_new_preg;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ready_tbl <= '1;
    end else begin
      if (i_phy_wr.valid) begin
        ready_tbl[i_phy_wr.preg] <= 1'b1;
      end
      if (w_accept) begin
        ready_tbl[w_new_preg] <= 1'b0;
      end
    end
  end

  // Free list starts full with the upper physical registers
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      fl_head <= '0;
      fl_tail <= '0;
      for (int i = 0; i < FREE_REG_NUM; i++) begin
        free_list[i] <= preg_t'(AREG_NUM + i);
      end
    end else begin
      if (w_accept) begin
        fl_head <= fl_head + 1'b1;
      end
      if (i_commit.valid) begin
        free_list[fl_tail] <= i_commit.free_preg;
        fl_tail            <= fl_tail + 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_rn_inst.valid <= 1'b0;
    end else begin
      o_rn_inst.valid <= w_accept;
      if (w_accept) begin
        o_rn_inst.op        <= i_disp.op;
        o_rn_inst.rob_id    <= i_rob_id;
        o_rn_inst.rd_preg   <= w_new_preg;
        o_rn_inst.old_preg  <= map_tbl[i_disp.rd];
        o_rn_inst.rs1_preg  <= w_rs1_preg;
        o_rn_inst.rs1_ready <= w_rs1_ready;
        o_rn_inst.rs2_preg  <= w_rs2_preg;
        o_rn_inst.rs2_ready <= w_rs2_ready;
        o_rn_inst.imm       <= i_disp.imm;
        o_rn_inst.rd_areg   <= i_disp.rd;
      end
    end
  end

endmodule

// ==== tile_pkg.sv ====
package tile_pkg;

  // ------------------------------------------------------------
  // Core sizes
  // ------------------------------------------------------------
  localparam int DATA_W       = 32;
  localparam int AREG_NUM     = 8;
  localparam int PREG_NUM     = 16;
  localparam int ROB_SIZE     = 8;
  localparam int RS_SIZE      = 4;
  localparam int FREE_REG_NUM = PREG_NUM - AREG_NUM;

  typedef logic [DATA_W-1:0]           data_t;
  typedef logic [$clog2(AREG_NUM)-1:0] areg_t;
  typedef logic [$clog2(PREG_NUM)-1:0] preg_t;
  typedef logic [$clog2(ROB_SIZE)-1:0] rob_id_t;

  typedef enum logic [2:0] {
    LI  = 3'd0,
    ADD = 3'd1,
    SUB = 3'd2,
    AND = 3'd3,
    XOR = 3'd4
  } alu_op_e;

  // ------------------------------------------------------------
  // Pipeline payloads
  // ------------------------------------------------------------
  // From the decoder before rename
  typedef struct packed {
    alu_op_e op;
    areg_t   rd;
    areg_t   rs1;
    areg_t   rs2;
    data_t   imm;
  } disp_inst_t;

  typedef struct packed {
    logic    valid;
    alu_op_e op;
    rob_id_t rob_id;
    preg_t   rd_preg;
    preg_t   old_preg;
    preg_t   rs1_preg;
    logic    rs1_ready;
    preg_t   rs2_preg;
    logic    rs2_ready;
    data_t   imm;
    areg_t   rd_areg;
  } rn_inst_t;

  typedef struct packed {
    logic    valid;
    alu_op_e op;
    rob_id_t rob_id;
    preg_t   rd_preg;
    preg_t   rs1_preg;
    preg_t   rs2_preg;
    data_t   imm;
  } issue_t;

  // Writeback broadcast that doubles as the wakeup tag
  typedef struct packed {
    logic  valid;
    preg_t preg;
    data_t data;
  } phy_wr_t;

  typedef struct packed {
    logic    valid;
    rob_id_t rob_id;
    data_t   data;
  } done_rpt_t;

  typedef struct packed {
    logic  valid;
    areg_t rd_areg;
    preg_t free_preg;
    data_t data;
  } commit_t;

endpackage
